// File: execConsts.svh
`ifndef EXEC_CONSTS_SVH
`define EXEC_CONSTS_SVH

// Operand and result width of the datapath
`define EXEC_DW 16

// Low bits of operand b used as shift distance
`define EXEC_SHW 4

// Cycles from inValid to resValid
`define EXEC_DEPTH 3

`endif

// File: execPkg.sv
`default_nettype none
`include "execConsts.svh"

package execPkg;

        // Micro-op codes issued by the control FSM of the core
        typedef enum logic [5:0] {
                OP_LW_1 = 6'b000000, // Load address phase
                OP_LW_2 = 6'b000001, // Load memory phase
                OP_LW_3 = 6'b000010, // Load writeback phase
                OP_SW_1 = 6'b000011, // Store address phase
                OP_SW_2 = 6'b000100, // Store data phase
                OP_MOV  = 6'b000101,
                OP_ADD  = 6'b000110,
                OP_SUB  = 6'b000111,
                OP_MUL  = 6'b001000,
                OP_DIV  = 6'b001001,
                OP_AND  = 6'b001010,
                OP_OR   = 6'b001011,
                OP_SHL  = 6'b001100,
                OP_SHR  = 6'b001101,
                OP_CMP  = 6'b001110, // Flags only
                OP_NOT  = 6'b001111,
                OP_JR   = 6'b010000, // Jump register
                OP_JPC  = 6'b010001, // Jump on condition
                OP_BRFL = 6'b010010, // Branch on stored flag
                OP_CALL = 6'b010011,
                OP_RET  = 6'b010100,
                OP_NOP  = 6'b010101
        } microOpE;

        // ALU function where code zero never occurs
        typedef enum logic [3:0] {
                FN_ADD      = 4'd1,
                FN_SUB      = 4'd2,
                FN_MUL      = 4'd3,
                FN_DIV      = 4'd4,
                FN_MOVE     = 4'd5,  // Pass b
                FN_LOADPASS = 4'd6,  // Pass a
                FN_AND      = 4'd7,
                FN_OR       = 4'd8,
                FN_SHL      = 4'd9,
                FN_SHR      = 4'd10,
                FN_CMP      = 4'd11,
                FN_NOT      = 4'd12,
                FN_JUMP     = 4'd13,
                FN_BRANCH   = 4'd14,
                FN_NOP      = 4'd15
        } aluFuncE;

        typedef struct packed {
                microOpE              microOp;
                logic [`EXEC_DW-1:0]  a;
                logic [`EXEC_DW-1:0]  b;
        } opInS;

        typedef struct packed {
                aluFuncE              func;
                logic [`EXEC_DW-1:0]  a;
                logic [`EXEC_DW-1:0]  b;
                logic                 writeEn;
                logic                 illegal;  // Code outside the table
        } decodedS;

        typedef struct packed {
                logic zero;   // a == b
                logic neg;    // Signed a < b
                logic carry;  // Unsigned a < b
        } flagsS;

        typedef struct packed {
                aluFuncE              func;
                logic [`EXEC_DW-1:0]  data;
                flagsS                flags;
                logic                 writeEn;
                logic                 divZero;
                logic                 illegal;
        } executedS;

        typedef struct packed {
                logic [`EXEC_DW-1:0]  data;
                logic                 writeEn;
                logic                 takeBranch;
                logic                 divZero;
                logic                 illegal;
        } resultS;

endpackage

`default_nettype wire

// File: aluControl.sv
`timescale 1ns/1ps
`default_nettype none

module aluControl (
        input  wire                clk,
        input  wire                rst,
        input  wire execPkg::opInS opIn,
        input  wire                inValid,
        output execPkg::decodedS   decoded,
        output logic               decValid
);

        execPkg::aluFuncE nextFunc;     // Decoded function
        logic             nextWriteEn;  // Result goes to a register
        logic             nextIllegal;

        // Micro-op to ALU function
        always_comb begin
                nextIllegal = 1'b0;                   // Cleared for every known code
                case (opIn.microOp)
                        execPkg::OP_LW_1, execPkg::OP_SW_1, execPkg::OP_ADD: begin
                                nextFunc = execPkg::FN_ADD;  // Address sum shares the adder
                        end
                        execPkg::OP_SUB:  nextFunc = execPkg::FN_SUB;
                        execPkg::OP_MUL:  nextFunc = execPkg::FN_MUL;
                        execPkg::OP_DIV:  nextFunc = execPkg::FN_DIV;
                        execPkg::OP_LW_2, execPkg::OP_SW_2, execPkg::OP_MOV: begin
                                nextFunc = execPkg::FN_MOVE;
                        end
                        execPkg::OP_LW_3: nextFunc = execPkg::FN_LOADPASS;  // Loaded word on a
                        execPkg::OP_AND:  nextFunc = execPkg::FN_AND;
                        execPkg::OP_OR:   nextFunc = execPkg::FN_OR;
                        execPkg::OP_SHL:  nextFunc = execPkg::FN_SHL;
                        execPkg::OP_SHR:  nextFunc = execPkg::FN_SHR;
                        execPkg::OP_CMP:  nextFunc = execPkg::FN_CMP;
                        execPkg::OP_NOT:  nextFunc = execPkg::FN_NOT;
                        execPkg::OP_JR, execPkg::OP_JPC,
                        execPkg::OP_CALL, execPkg::OP_RET: begin
                                nextFunc = execPkg::FN_JUMP;  // All unconditional here
                        end
                        execPkg::OP_BRFL: nextFunc = execPkg::FN_BRANCH;
                        execPkg::OP_NOP:  nextFunc = execPkg::FN_NOP;
                        default: begin
                                nextFunc    = execPkg::FN_NOP;  // Unknown code does nothing
                                nextIllegal = 1'b1;
                        end
                endcase
        end

        // Write-enable class
        always_comb begin
                case (opIn.microOp)
                        execPkg::OP_ADD, execPkg::OP_SUB, execPkg::OP_MUL,
                        execPkg::OP_DIV, execPkg::OP_MOV, execPkg::OP_AND,
                        execPkg::OP_OR, execPkg::OP_SHL, execPkg::OP_SHR,
                        execPkg::OP_NOT, execPkg::OP_LW_3: begin
                                nextWriteEn = 1'b1;
                        end
                        default: begin
                                nextWriteEn = 1'b0;  // Address phases, CMP, jumps, NOP
                        end
                endcase
        end

        always_ff @(posedge clk) begin
                if (rst) begin
                        decValid <= 1'b0;
                end else begin
                        decValid <= inValid;  // One cycle through decode
                end
        end

        // Payload follows the input every cycle
        always_ff @(posedge clk) begin
                decoded.func    <= nextFunc;
                decoded.a       <= opIn.a;
                decoded.b       <= opIn.b;
                decoded.writeEn <= nextWriteEn;
                decoded.illegal <= nextIllegal;
        end

        // Valid resolves once reset has been applied
        assert property (@(posedge clk) disable iff (rst) !$isunknown(decValid))
                else $error("aluControl: decValid unknown after reset");

endmodule

`default_nettype wire

// File: aluCore.sv
`timescale 1ns/1ps
`default_nettype none
`include "execConsts.svh"

module aluCore (
        input  wire                   clk,
        input  wire                   rst,
        input  wire execPkg::decodedS decoded,
        input  wire                   decValid,
        output execPkg::executedS     executed,
        output logic                  exeValid
);

        logic [`EXEC_DW-1:0]  nextData;
        logic                 nextDivZero;
        execPkg::flagsS       nextFlags;
        logic [`EXEC_SHW-1:0] shAmt;      // Shift distance from b

        assign shAmt = decoded.b[`EXEC_SHW-1:0];

        // Compare flags for every op but only CMP's are kept
        always_comb begin
                nextFlags.zero  = (decoded.a == decoded.b);
                nextFlags.neg   = ($signed(decoded.a) < $signed(decoded.b));
                nextFlags.carry = (decoded.a < decoded.b);  // Unsigned borrow
        end

        // Result per function
        always_comb begin
                nextDivZero = 1'b0;
                case (decoded.func)
                        execPkg::FN_ADD:      nextData = decoded.a + decoded.b;
                        execPkg::FN_SUB:      nextData = decoded.a - decoded.b;
                        execPkg::FN_MUL:      nextData = decoded.a * decoded.b;  // Low half
                        execPkg::FN_DIV: begin
                                if (decoded.b == '0) begin
                                        nextData    = '1;    // Saturate on divide by zero
                                        nextDivZero = 1'b1;
                                end else begin
                                        nextData = decoded.a / decoded.b;  // Unsigned quotient
                                end
                        end
                        execPkg::FN_MOVE:     nextData = decoded.b;
                        execPkg::FN_LOADPASS: nextData = decoded.a;
                        execPkg::FN_AND:      nextData = decoded.a & decoded.b;
                        execPkg::FN_OR:       nextData = decoded.a | decoded.b;
                        execPkg::FN_SHL:      nextData = decoded.a << shAmt;
                        execPkg::FN_SHR:      nextData = decoded.a >> shAmt;  // Logical
                        execPkg::FN_NOT:      nextData = ~decoded.a;
                        execPkg::FN_JUMP,
                        execPkg::FN_BRANCH:   nextData = decoded.b;  // Target address
                        default: begin
                                nextData = '0;  // CMP and NOP
                        end
                endcase
        end

        always_ff @(posedge clk) begin
                if (rst) begin
                        exeValid <= 1'b0;
                end else begin
                        exeValid <= decValid;
                end
        end

        always_ff @(posedge clk) begin
                executed.func    <= decoded.func;
                executed.data    <= nextData;
                executed.flags   <= nextFlags;
                executed.writeEn <= decoded.writeEn;
                executed.divZero <= nextDivZero;
                executed.illegal <= decoded.illegal;  // Passed through to result
        end

        // Divide fault only ever comes from a divide
        assert property (@(posedge clk) disable iff (rst)
                (exeValid && executed.divZero) |-> (executed.func == execPkg::FN_DIV))
                else $error("aluCore: divZero without DIV");

endmodule

`default_nettype wire

// File: flagStage.sv
`timescale 1ns/1ps
`default_nettype none

module flagStage (
        input  wire                    clk,
        input  wire                    rst,
        input  wire execPkg::executedS executed,
        input  wire                    exeValid,
        output execPkg::resultS        result,
        output logic                   resValid
);

        execPkg::flagsS flagReg;   // Flags of the last CMP
        logic           nextTake;  // Branch decision

        // Jumps always go and BRANCH tests the stored zero flag
        always_comb begin
                case (executed.func)
                        execPkg::FN_JUMP:   nextTake = exeValid;
                        execPkg::FN_BRANCH: nextTake = exeValid && flagReg.zero;
                        default:            nextTake = 1'b0;
                endcase
        end

        // Flags change only as a valid CMP leaves
        always_ff @(posedge clk) begin
                if (rst) begin
                        flagReg <= '0;
                end else if (exeValid && (executed.func == execPkg::FN_CMP)) begin
                        flagReg <= executed.flags;
                end
        end

        always_ff @(posedge clk) begin
                if (rst) begin
                        resValid <= 1'b0;
                end else begin
                        resValid <= exeValid;  // Third and last stage
                end
        end

        always_ff @(posedge clk) begin
                result.data       <= executed.data;
                result.writeEn    <= executed.writeEn;
                result.takeBranch <= nextTake;  // Already qualified by valid
                result.divZero    <= executed.divZero;
                result.illegal    <= executed.illegal;
        end

        // No branch is reported on an idle cycle
        assert property (@(posedge clk) disable iff (rst) result.takeBranch |-> resValid)
                else $error("flagStage: takeBranch without resValid");

endmodule

`default_nettype wire

// File: execTop.sv
`timescale 1ns/1ps
`default_nettype none

module execTop (
        input  wire                clk,
        input  wire                rst,
        input  wire execPkg::opInS opIn,
        input  wire                inValid,
        output execPkg::resultS    result,
        output logic               resValid
);

        execPkg::decodedS  decoded;   // Decode to execute
        logic              decValid;
        execPkg::executedS executed;  // Execute to flags
        logic              exeValid;

        aluControl i_aluControl (
                .clk      (clk),
                .rst      (rst),
                .opIn     (opIn),
                .inValid  (inValid),
                .decoded  (decoded),
                .decValid (decValid)
        );

        aluCore i_aluCore (
                .clk      (clk),
                .rst      (rst),
                .decoded  (decoded),
                .decValid (decValid),
                .executed (executed),
                .exeValid (exeValid)
        );

        flagStage i_flagStage (
                .clk      (clk),
                .rst      (rst),
                .executed (executed),
                .exeValid (exeValid),
                .result   (result),
                .resValid (resValid)
        );

endmodule

`default_nettype wire

// File: tbExecTop.sv
`timescale 1ns/1ps
`default_nettype none
`include "execConsts.svh"

module tbExecTop;

        localparam int NUM_ARITH    = 40;
        localparam int NUM_DIV      = 10;
        localparam int NUM_TESTS    = 6;
        localparam int ISSUE_SLOTS  = 6 + NUM_ARITH + 10 + NUM_DIV + 8 + 7;  // Idle gaps included
        localparam int WATCH_CYCLES = ISSUE_SLOTS + NUM_TESTS * (`EXEC_DEPTH + 2) + 20;

        logic                   clk;
        logic                   rst;
        execPkg::opInS          opIn;
        logic                   inValid;
        execPkg::resultS        result;
        logic                   resValid;

        logic [31:0]            lfsr = 32'h8c32;                 // Operand source
        execPkg::flagsS         modelFlags;                      // Model copy of the CMP flags
        execPkg::resultS        expPipe [0:`EXEC_DEPTH-1];       // Expected results in flight
        logic [`EXEC_DEPTH-1:0] expValid;
        int                     errCount    = 0;
        int                     checked     = 0;
        int                     testsRun    = 0;
        int                     testsFailed = 0;
        int                     startErr;
        execPkg::microOpE       arithOps [0:8] = '{execPkg::OP_ADD, execPkg::OP_SUB,
                execPkg::OP_MUL, execPkg::OP_AND, execPkg::OP_OR, execPkg::OP_SHL,
                execPkg::OP_SHR, execPkg::OP_NOT, execPkg::OP_MOV};

        execTop i_execTop (
                .clk      (clk),
                .rst      (rst),
                .opIn     (opIn),
                .inValid  (inValid),
                .result   (result),
                .resValid (resValid)
        );

        initial begin
                clk = 1'b0;
                forever #20 clk = ~clk;  // 40 ns period
        end

        // Taps 32, 22, 2, 1
        function automatic logic [31:0] lfsrNext(input logic [31:0] s);
                return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
        endfunction

        function automatic logic [`EXEC_DW-1:0] takeBits(input int n);
                logic [`EXEC_DW-1:0] v;
                v = '0;
                for (int i = 0; i < n; i++) begin
                        lfsr = lfsrNext(lfsr);  // One step per bit
                        v    = {v[`EXEC_DW-2:0], lfsr[0]};
                end
                return v;
        endfunction

        // Expected output for one micro-op
        function automatic execPkg::resultS modelResult(input execPkg::opInS op,
                                                        input logic zeroFlag);
                execPkg::resultS r;
                r = '0;
                r.writeEn = op.microOp inside {execPkg::OP_ADD, execPkg::OP_SUB,
                        execPkg::OP_MUL, execPkg::OP_DIV, execPkg::OP_MOV, execPkg::OP_AND,
                        execPkg::OP_OR, execPkg::OP_SHL, execPkg::OP_SHR, execPkg::OP_NOT,
                        execPkg::OP_LW_3};
                case (op.microOp)
                        execPkg::OP_ADD, execPkg::OP_LW_1, execPkg::OP_SW_1: r.data = op.a + op.b;
                        execPkg::OP_SUB: r.data = op.a - op.b;
                        execPkg::OP_MUL: r.data = op.a * op.b;  // Low half only
                        execPkg::OP_DIV: begin
                                r.divZero = (op.b == '0);
                                r.data    = r.divZero ? '1 : op.a / op.b;
                        end
                        execPkg::OP_MOV, execPkg::OP_LW_2, execPkg::OP_SW_2: r.data = op.b;
                        execPkg::OP_LW_3: r.data = op.a;
                        execPkg::OP_AND:  r.data = op.a & op.b;
                        execPkg::OP_OR:   r.data = op.a | op.b;
                        execPkg::OP_SHL:  r.data = op.a << op.b[`EXEC_SHW-1:0];
                        execPkg::OP_SHR:  r.data = op.a >> op.b[`EXEC_SHW-1:0];
                        execPkg::OP_NOT:  r.data = ~op.a;
                        execPkg::OP_JR, execPkg::OP_JPC, execPkg::OP_CALL, execPkg::OP_RET: begin
                                r.data       = op.b;  // Target
                                r.takeBranch = 1'b1;
                        end
                        execPkg::OP_BRFL: begin
                                r.data       = op.b;
                                r.takeBranch = zeroFlag;
                        end
                        execPkg::OP_CMP, execPkg::OP_NOP: r.data = '0;
                        default: r.illegal = 1'b1;  // Outside the table
                endcase
                return r;
        endfunction

        // Model pipeline with one entry per cycle of latency
        always @(posedge clk) begin
                if (rst) begin
                        expValid   <= '0;
                        modelFlags = '0;
                end else begin
                        expValid   <= {expValid[`EXEC_DEPTH-2:0], inValid};
                        expPipe[0] <= modelResult(opIn, modelFlags.zero);
                        for (int i = 1; i < `EXEC_DEPTH; i++) begin
                                expPipe[i] <= expPipe[i-1];
                        end
                        if (inValid && opIn.microOp == execPkg::OP_CMP) begin
                                modelFlags.zero  = (opIn.a == opIn.b);
                                modelFlags.neg   = ($signed(opIn.a) < $signed(opIn.b));
                                modelFlags.carry = (opIn.a < opIn.b);
                        end
                        if (resValid) begin
                                checked++;
                        end
                end
        end

        assert property (@(posedge clk) disable iff (rst) resValid == expValid[`EXEC_DEPTH-1])
                else begin
                        errCount++;
                        $display("Fail %0t: resValid %b, expected %b", $time, $sampled(resValid),
                                 $sampled(expValid[`EXEC_DEPTH-1]));
                end

        assert property (@(posedge clk) disable iff (rst)
                resValid |-> result.data == expPipe[`EXEC_DEPTH-1].data)
                else begin
                        errCount++;
                        $display("Fail %0t: data %h, expected %h", $time, $sampled(result.data),
                                 $sampled(expPipe[`EXEC_DEPTH-1].data));
                end

        // writeEn, takeBranch, divZero, illegal
        assert property (@(posedge clk) disable iff (rst)
                resValid |-> result[3:0] == expPipe[`EXEC_DEPTH-1][3:0])
                else begin
                        errCount++;
                        $display("Fail %0t: control bits %b, expected %b", $time,
                                 $sampled(result[3:0]), $sampled(expPipe[`EXEC_DEPTH-1][3:0]));
                end

        initial begin
                #(WATCH_CYCLES * 40);
                $display("Timeout: the run did not finish within %0d cycles", WATCH_CYCLES);
                $display("FAIL: see errors above");
                $finish;
        end

        task automatic issue(input execPkg::microOpE code, input logic [`EXEC_DW-1:0] a,
                             input logic [`EXEC_DW-1:0] b);
                @(posedge clk);
                opIn.microOp <= code;
                opIn.a       <= a;
                opIn.b       <= b;
                inValid      <= 1'b1;
        endtask

        task automatic idle();
                @(posedge clk);
                inValid <= 1'b0;
        endtask

        task automatic drain();
                idle();
                @(posedge clk);
                while (expValid != '0) begin  // Until the last result was checked
                        @(posedge clk);
                end
        endtask

        task automatic endTest(input string name);
                testsRun++;
                if (errCount == startErr) begin
                        $display("Test %s: ok", name);
                end else begin
                        testsFailed++;
                        $display("Test %s: %0d errors", name, errCount - startErr);
                end
                startErr = errCount;
        endtask

        initial begin
                logic [`EXEC_DW-1:0] opA;
                rst      = 1'b1;
                inValid  = 1'b0;
                opIn     = '0;
                startErr = 0;
                repeat (3) @(posedge clk);
                rst <= 1'b0;

                repeat (5) idle();  // No resValid while empty
                issue(execPkg::OP_ADD, takeBits(16), takeBits(16));
                drain();
                endTest("reset and first result");

                for (int i = 0; i < NUM_ARITH; i++) begin
                        issue(arithOps[takeBits(4) % 9], takeBits(16), takeBits(16));
                end
                drain();
                endTest("back-to-back arithmetic and logic");

                for (int i = 0; i < 2; i++) begin
                        issue(execPkg::OP_LW_1, takeBits(16), takeBits(16));
                        issue(execPkg::OP_LW_2, takeBits(16), takeBits(16));
                        issue(execPkg::OP_LW_3, takeBits(16), takeBits(16));
                        issue(execPkg::OP_SW_1, takeBits(16), takeBits(16));
                        issue(execPkg::OP_SW_2, takeBits(16), takeBits(16));
                end
                drain();
                endTest("load and store phases");

                for (int i = 0; i < NUM_DIV; i++) begin
                        issue(execPkg::OP_DIV, takeBits(16), (i % 5 == 4) ? '0 : takeBits(8) + 1);
                end
                drain();
                endTest("divide and divide by zero");

                opA = takeBits(16);
                issue(execPkg::OP_CMP, opA, opA);   // Equal operands take the branch
                issue(execPkg::OP_BRFL, '0, takeBits(16));
                issue(execPkg::OP_CMP, opA, ~opA);  // Unequal operands do not
                issue(execPkg::OP_BRFL, '0, takeBits(16));
                issue(execPkg::OP_JR, takeBits(16), takeBits(16));
                issue(execPkg::OP_JPC, takeBits(16), takeBits(16));
                issue(execPkg::OP_CALL, takeBits(16), takeBits(16));
                issue(execPkg::OP_RET, takeBits(16), takeBits(16));
                drain();
                endTest("compare, branch and jumps");

                issue(execPkg::microOpE'(6'd22), takeBits(16), takeBits(16));
                idle();
                issue(execPkg::microOpE'(6'd45), takeBits(16), takeBits(16));
                idle();
                idle();
                issue(execPkg::microOpE'(6'd63), takeBits(16), takeBits(16));
                issue(execPkg::OP_NOP, takeBits(16), takeBits(16));
                drain();
                endTest("illegal codes and issue gaps");

                $display("Tests run %0d, failed %0d, results checked %0d, errors %0d",
                         testsRun, testsFailed, checked, errCount);
                if (errCount == 0) begin
                        $display("PASS: all tests");
                end else begin
                        $display("FAIL: see errors above");
                end
                $finish;
        end

endmodule

`default_nettype wire

// File: files.f
+incdir+.
execPkg.sv
aluControl.sv
aluCore.sv
flagStage.sv
execTop.sv
tbExecTop.sv
